// File: build.f
+incdir+include
source/hero_pkg.sv
source/l2_mem.sv
source/l2_atomics.sv
source/soc_bus.sv
source/pulp_cluster.sv
source/hero.sv
test/tb_hero.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hero
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_hero.sv
`include "hero_settings.svh"

module tb_hero;
  timeunit 1ns;
  timeprecision 1ps;
  import hero_pkg::*;

  localparam int unsigned N_CL       = `HERO_N_CLUSTERS;
  localparam int unsigned L2_WORDS   = `HERO_L2_WORDS;
  localparam int unsigned WAIT_LIMIT = 2000;
  localparam addr_t       DONE_ADR   = addr_t'(`HERO_DONE_ADDR);

  logic            clk_i;
  logic            reset_i;
  logic [N_CL-1:0] cl_fetch_en;
  logic [N_CL-1:0] cl_eoc;
  logic [N_CL-1:0] cl_busy;
  wb_req_t         host_req;
  wb_rsp_t         host_rsp;
  logic            stim_started;
  int unsigned     jobs;

  // expected L2 contents by full word address
  data_t model [2**`HERO_AW];

  hero dut (
    .clk_i,
    .reset_i,
    .cl_fetch_en_i (cl_fetch_en),
    .cl_eoc_o      (cl_eoc),
    .cl_busy_o     (cl_busy),
    .host_req_i    (host_req),
    .host_rsp_o    (host_rsp)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  // quiet outputs until the first host access
  assert property (@(posedge clk_i) disable iff (reset_i)
    !stim_started |-> (cl_busy == '0 && cl_eoc == '0 && !host_rsp.ack && !host_rsp.err))
    else report_failure("outputs active after reset before any stimulus");

  assert property (@(posedge clk_i) disable iff (reset_i) !(host_rsp.ack && host_rsp.err))
    else report_failure("host port saw ack and err in the same cycle");
  assert property (@(posedge clk_i) disable iff (reset_i) host_rsp.ack |=> !host_rsp.ack)
    else report_failure("host ack lasted more than one cycle");
  assert property (@(posedge clk_i) disable iff (reset_i) host_rsp.err |=> !host_rsp.err)
    else report_failure("host err lasted more than one cycle");

  for (genvar i = 0; i < N_CL; i++) begin : gen_cl_checks
    assert property (@(posedge clk_i) disable iff (reset_i) !(cl_busy[i] && cl_eoc[i]))
      else report_failure($sformatf("cluster %0d busy and eoc high together", i));
    // busy ends exactly when eoc starts
    assert property (@(posedge clk_i) disable iff (reset_i) $fell(cl_busy[i]) |-> $rose(cl_eoc[i]))
      else report_failure($sformatf("cluster %0d left busy without raising eoc", i));
  end

  task automatic check_word(input string name, input addr_t adr, input data_t got,
                            input data_t exp);
    assert (got == exp)
      else report_failure($sformatf("Mismatch %s at word %h: got %h, expected %h",
                                    name, adr, got, exp));
  endtask

  // host port access held until ack or err
  task automatic host_access(input logic we, input addr_t adr, input data_t dat,
                             input sel_t sel, input amo_op_e op, output data_t rdat,
                             output logic got_ack, output logic got_err);
    int unsigned n;
    logic        done;
    stim_started = 1'b1;
    @(negedge clk_i);
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = dat;
    host_req.sel = sel;
    host_req.tgc = op;
    done = 1'b0;
    n    = 0;
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      if (host_rsp.ack || host_rsp.err) begin
        done = 1'b1;
      end else begin
        n++;
      end
    end
    if (!done) begin
      report_failure($sformatf("no answer on the host port for word %h", adr));
    end else begin
      rdat     = host_rsp.dat;
      got_ack  = host_rsp.ack;
      got_err  = host_rsp.err;
      host_req = '0;
    end
  endtask

  task automatic host_write(input addr_t adr, input data_t dat, input sel_t sel);
    data_t rdat;
    logic  ack;
    logic  err;
    host_access(1'b1, adr, dat, sel, AMO_NONE, rdat, ack, err);
    assert (ack && !err)
      else report_failure($sformatf("host write to word %h was not acknowledged", adr));
    for (int b = 0; b < `HERO_DW / 8; b++) begin
      if (sel[b]) begin
        model[adr][8*b +: 8] = dat[8*b +: 8];
      end
    end
  endtask

  task automatic host_read(input addr_t adr, output data_t rdat);
    logic ack;
    logic err;
    host_access(1'b0, adr, '0, '1, AMO_NONE, rdat, ack, err);
    assert (ack && !err)
      else report_failure($sformatf("host read of word %h was not acknowledged", adr));
  endtask

  task automatic read_check(input addr_t adr);
    data_t rdat;
    host_read(adr, rdat);
    check_word("host_rsp_o.dat", adr, rdat, model[adr]);
  endtask

  task automatic check_all();
    for (int w = 0; w < L2_WORDS; w++) begin
      read_check(addr_t'(w));
    end
  endtask

  task automatic amo_check(input amo_op_e op, input addr_t adr, input data_t dat);
    data_t old;
    logic  ack;
    logic  err;
    host_access(1'b0, adr, dat, '1, op, old, ack, err);
    assert (ack && !err)
      else report_failure($sformatf("host atomic on word %h was not acknowledged", adr));
    check_word("host_rsp_o.dat (old word)", adr, old, model[adr]);
    if (op == AMO_ADD) begin
      model[adr] = model[adr] + dat;
    end else begin
      model[adr] = dat;
    end
    read_check(adr);
  endtask

  // pulse fetch enable for the masked clusters and wait for all of them
  task automatic run_clusters(input logic [N_CL-1:0] mask);
    int unsigned n;
    addr_t       adr;
    @(negedge clk_i);
    cl_fetch_en = mask;
    @(negedge clk_i);
    cl_fetch_en = '0;
    assert ((cl_busy & mask) == mask)
      else report_failure($sformatf("Mismatch cl_busy_o: got %h, expected %h", cl_busy, mask));
    n = 0;
    while ((cl_eoc & mask) != mask && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if ((cl_eoc & mask) != mask) begin
      report_failure($sformatf("clusters %b did not reach eoc in time", mask));
    end
    for (int c = 0; c < N_CL; c++) begin
      if (mask[c]) begin
        for (int j = 0; j < `HERO_JOB_LEN; j++) begin
          adr        = addr_t'(c * `HERO_CLUSTER_STRIDE + j);
          model[adr] = model[adr] + data_t'(c + 1);
        end
        model[DONE_ADR] = model[DONE_ADR] + 1;
        jobs++;
      end
    end
  endtask

  initial begin
    addr_t       wr_adr [16];
    addr_t       adr;
    data_t       rdat;
    logic        ack;
    logic        err;
    amo_op_e     op;
    int unsigned cl;

    reset_i      = 1'b1;
    cl_fetch_en  = '0;
    host_req     = '0;
    stim_started = 1'b0;
    jobs         = 0;
    void'($urandom(32'hcc11_5bd3));
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (4) @(negedge clk_i);

    // full-word preload so every word is defined
    for (int w = 0; w < L2_WORDS; w++) begin
      host_write(addr_t'(w), data_t'($urandom), '1);
    end
    for (int k = 0; k < 16; k++) begin
      wr_adr[k] = addr_t'($urandom_range(0, L2_WORDS - 1));
      host_write(wr_adr[k], data_t'($urandom), sel_t'($urandom));
    end
    for (int k = 0; k < 16; k++) begin
      read_check(wr_adr[k]);
    end

    // clear the completion counter before a single job
    host_write(DONE_ADR, '0, '1);
    jobs = 0;
    cl = $urandom_range(0, N_CL - 1);
    run_clusters(N_CL'(1) << cl);
    check_all();

    // all clusters contend for the bus and the counter
    run_clusters('1);
    check_all();
    host_read(DONE_ADR, rdat);
    check_word("host_rsp_o.dat (completion counter)", DONE_ADR, rdat, data_t'(jobs));

    for (int k = 0; k < 8; k++) begin
      adr = addr_t'($urandom_range(0, L2_WORDS - 2));
      op  = (k % 2 == 1) ? AMO_ADD : AMO_SWAP;
      amo_check(op, adr, data_t'($urandom));
    end

    // unmapped words must not alias into L2
    for (int k = 0; k < 4; k++) begin
      adr = addr_t'($urandom_range(L2_WORDS, 2**`HERO_AW - 1));
      host_access(1'b1, adr, data_t'($urandom), '1, AMO_NONE, rdat, ack, err);
      assert (err && !ack)
        else report_failure($sformatf("unmapped word %h did not end with err alone", adr));
      read_check(addr_t'(adr[7:0]));
    end
    check_all();

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: source/hero.sv
`include "hero_settings.svh"

module hero #(
  parameter int unsigned N_CLUSTERS = `HERO_N_CLUSTERS
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,
  input  hero_pkg::wb_req_t     host_req_i,
  output hero_pkg::wb_rsp_t     host_rsp_o
);
  import hero_pkg::*;

  // masters 0..N_CLUSTERS-1 are clusters, the last one is the host
  wb_req_t [N_CLUSTERS:0] mst_req;
  wb_rsp_t [N_CLUSTERS:0] mst_rsp;
  wb_req_t                l2_req;
  wb_rsp_t                l2_rsp;
  mem_req_t               mem_req;
  data_t                  mem_rdata;

  assign mst_req[N_CLUSTERS] = host_req_i;
  assign host_rsp_o          = mst_rsp[N_CLUSTERS];

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_clusters
    pulp_cluster #(
      .CLUSTER_ID (i)
    ) i_cluster (
      .clk_i,
      .reset_i,
      .fetch_en_i (cl_fetch_en_i[i]),
      .eoc_o      (cl_eoc_o[i]),
      .busy_o     (cl_busy_o[i]),
      .wb_req_o   (mst_req[i]),
      .wb_rsp_i   (mst_rsp[i])
    );
  end

  soc_bus #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_soc_bus (
    .clk_i,
    .reset_i,
    .mst_req_i (mst_req),
    .mst_rsp_o (mst_rsp),
    .slv_req_o (l2_req),
    .slv_rsp_i (l2_rsp)
  );

  l2_atomics i_atomics (
    .clk_i,
    .reset_i,
    .wb_req_i    (l2_req),
    .wb_rsp_o    (l2_rsp),
    .mem_req_o   (mem_req),
    .mem_rdata_i (mem_rdata)
  );

  l2_mem i_l2_mem (
    .clk_i,
    .mem_req_i (mem_req),
    .rdata_o   (mem_rdata)
  );

endmodule

// File: source/pulp_cluster.sv
`include "hero_settings.svh"

module pulp_cluster #(
  parameter int unsigned CLUSTER_ID = 0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              fetch_en_i,
  output logic              eoc_o,
  output logic              busy_o,
  output hero_pkg::wb_req_t wb_req_o,
  input  hero_pkg::wb_rsp_t wb_rsp_i
);
  import hero_pkg::*;

  localparam int unsigned IDX_W = $clog2(`HERO_JOB_LEN);
  localparam addr_t BASE_ADR = addr_t'(CLUSTER_ID * `HERO_CLUSTER_STRIDE);
  localparam data_t INCR = data_t'(CLUSTER_ID + 1);

  cl_state_e        state_q;
  logic             fetch_q;
  logic             start;
  logic [IDX_W-1:0] idx_q;
  data_t            data_q;
  wb_req_t          req_q;
  wb_req_t          nxt_req;

  assign start = fetch_en_i & ~fetch_q;

  assign busy_o   = (state_q == CL_READ) || (state_q == CL_WRITE) || (state_q == CL_AMO);
  assign eoc_o    = (state_q == CL_DONE);
  assign wb_req_o = req_q;

  // access the current state wants to launch
  always_comb begin
    nxt_req     = '0;
    nxt_req.cyc = 1'b1;
    nxt_req.stb = 1'b1;
    nxt_req.sel = '1;
    nxt_req.tgc = AMO_NONE;
    case (state_q)
      CL_READ: begin
        nxt_req.adr = BASE_ADR + addr_t'(idx_q);
      end
      CL_WRITE: begin
        nxt_req.we  = 1'b1;
        nxt_req.adr = BASE_ADR + addr_t'(idx_q);
        nxt_req.dat = data_q + INCR;
      end
      CL_AMO: begin
        nxt_req.adr = addr_t'(`HERO_DONE_ADDR);
        nxt_req.dat = data_t'(1);
        nxt_req.tgc = AMO_ADD;
      end
      default: begin
        nxt_req.cyc = 1'b0;
        nxt_req.stb = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= CL_IDLE;
      fetch_q   <= 1'b0;
      idx_q     <= '0;
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
    end else begin
      fetch_q <= fetch_en_i;
      case (state_q)
        CL_IDLE, CL_DONE: begin
          if (start) begin
            state_q <= CL_READ;
            idx_q   <= '0;
          end
        end
        default: begin
          if (!req_q.stb) begin
            req_q <= nxt_req;
          end else if (wb_rsp_i.ack || wb_rsp_i.err) begin
            // release the bus for at least one cycle
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            if (wb_rsp_i.err) begin
              state_q <= CL_DONE;
            end else if (state_q == CL_READ) begin
              state_q <= CL_WRITE;
            end else if (state_q == CL_WRITE) begin
              if (idx_q == IDX_W'(`HERO_JOB_LEN - 1)) begin
                state_q <= CL_AMO;
              end else begin
                idx_q   <= idx_q + 1'b1;
                state_q <= CL_READ;
              end
            end else begin
              state_q <= CL_DONE;
            end
          end
        end
      endcase
    end
  end

  // word fetched in the read phase
  always_ff @(posedge clk_i) begin
    if (state_q == CL_READ && req_q.stb && wb_rsp_i.ack) begin
      data_q <= wb_rsp_i.dat;
    end
  end

endmodule

// File: source/soc_bus.sv
`include "hero_settings.svh"

module soc_bus #(
  parameter int unsigned N_CLUSTERS = `HERO_N_CLUSTERS
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  hero_pkg::wb_req_t [N_CLUSTERS:0]   mst_req_i,
  output hero_pkg::wb_rsp_t [N_CLUSTERS:0]   mst_rsp_o,
  output hero_pkg::wb_req_t                  slv_req_o,
  input  hero_pkg::wb_rsp_t                  slv_rsp_i
);
  import hero_pkg::*;

  // clusters plus the host port
  localparam int unsigned N_MST = N_CLUSTERS + 1;
  localparam int unsigned IDX_W = $clog2(N_MST);

  logic [IDX_W-1:0] grant_q;
  logic             grant_valid_q;
  logic [IDX_W-1:0] pick;
  logic             pick_valid;
  wb_req_t          cur_req;
  logic             active;
  logic             mapped;
  logic             err_done_q;
  logic             err_local;

  // round robin, search starts after the last grant
  always_comb begin : arb
    int cand;
    pick_valid = 1'b0;
    pick       = grant_q;
    for (int k = 1; k <= N_MST; k++) begin
      cand = (int'(grant_q) + k) % N_MST;
      if (!pick_valid && mst_req_i[cand].cyc) begin
        pick_valid = 1'b1;
        pick       = IDX_W'(cand);
      end
    end
  end

  // grant is held as long as the owner keeps cyc
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grant_q       <= '0;
      grant_valid_q <= 1'b0;
    end else if (!grant_valid_q || !mst_req_i[grant_q].cyc) begin
      grant_valid_q <= pick_valid;
      if (pick_valid) begin
        grant_q <= pick;
      end
    end
  end

  assign cur_req = mst_req_i[grant_q];
  assign active  = grant_valid_q & cur_req.cyc & cur_req.stb;
  assign mapped  = cur_req.adr < addr_t'(`HERO_L2_WORDS);

  // unmapped accesses never reach L2
  assign slv_req_o = (grant_valid_q && mapped) ? cur_req : '0;

  // local error responder, one pulse per strobe
  assign err_local = active & ~mapped & ~err_done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_done_q <= 1'b0;
    end else begin
      err_done_q <= active & ~mapped;
    end
  end

  // answer only the granted master
  always_comb begin
    for (int i = 0; i < N_MST; i++) begin
      mst_rsp_o[i] = '0;
      if (grant_valid_q && grant_q == IDX_W'(i)) begin
        mst_rsp_o[i].ack = slv_rsp_i.ack;
        mst_rsp_o[i].err = slv_rsp_i.err | err_local;
        mst_rsp_o[i].dat = slv_rsp_i.dat;
      end
    end
  end

endmodule

// File: source/l2_atomics.sv
module l2_atomics (
  input  logic               clk_i,
  input  logic               reset_i,
  input  hero_pkg::wb_req_t  wb_req_i,
  output hero_pkg::wb_rsp_t  wb_rsp_o,
  output hero_pkg::mem_req_t mem_req_o,
  input  hero_pkg::data_t    mem_rdata_i
);
  import hero_pkg::*;

  typedef enum logic [1:0] {
    AT_IDLE,
    AT_WRITE,
    AT_ACK
  } at_state_e;

  at_state_e state_q;
  logic      req_valid;
  logic      is_amo;

  assign req_valid = wb_req_i.cyc & wb_req_i.stb;
  assign is_amo    = (wb_req_i.tgc != AMO_NONE);

  always_comb begin
    mem_req_o       = '0;
    mem_req_o.addr  = wb_req_i.adr;
    mem_req_o.wdata = wb_req_i.dat;
    case (state_q)
      AT_IDLE: begin
        // an atomic starts with a plain read
        mem_req_o.en = req_valid;
        mem_req_o.we = wb_req_i.we & ~is_amo;
        mem_req_o.be = wb_req_i.sel;
      end
      AT_WRITE: begin
        mem_req_o.en = 1'b1;
        mem_req_o.we = 1'b1;
        mem_req_o.be = '1;
        if (wb_req_i.tgc == AMO_ADD) begin
          mem_req_o.wdata = mem_rdata_i + wb_req_i.dat;
        end
      end
      default: begin
        mem_req_o.en = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= AT_IDLE;
    end else begin
      case (state_q)
        AT_IDLE: begin
          if (req_valid) begin
            state_q <= is_amo ? AT_WRITE : AT_ACK;
          end
        end
        AT_WRITE: state_q <= AT_ACK;
        default:  state_q <= AT_IDLE;
      endcase
    end
  end

  // read-first memory still shows the old word during the ack
  assign wb_rsp_o.ack = (state_q == AT_ACK);
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = mem_rdata_i;

endmodule

// File: source/l2_mem.sv
`include "hero_settings.svh"

module l2_mem (
  input  logic               clk_i,
  input  hero_pkg::mem_req_t mem_req_i,
  output hero_pkg::data_t    rdata_o
);
  import hero_pkg::*;

  localparam int unsigned IDX_W   = $clog2(`HERO_L2_WORDS);
  localparam int unsigned N_BYTES = `HERO_DW / 8;

  data_t            mem_q [`HERO_L2_WORDS];
  logic [IDX_W-1:0] idx;

  // only the low address bits select a word
  assign idx = mem_req_i.addr[IDX_W-1:0];

  // read-first, the old word is registered on a write too
  always_ff @(posedge clk_i) begin
    if (mem_req_i.en) begin
      rdata_o <= mem_q[idx];
      if (mem_req_i.we) begin
        for (int b = 0; b < N_BYTES; b++) begin
          if (mem_req_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: source/hero_pkg.sv
`include "hero_settings.svh"

package hero_pkg;

  typedef logic [`HERO_AW-1:0]   addr_t;
  typedef logic [`HERO_DW-1:0]   data_t;
  typedef logic [`HERO_DW/8-1:0] sel_t;

  // carried in the wishbone cycle tag
  typedef enum logic [1:0] {
    AMO_NONE,
    AMO_ADD,
    AMO_SWAP
  } amo_op_e;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    addr_t   adr;
    data_t   dat;
    sel_t    sel;
    amo_op_e tgc;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // single-port memory cycle
  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    data_t wdata;
    sel_t  be;
  } mem_req_t;

  typedef enum logic [2:0] {
    CL_IDLE,
    CL_READ,
    CL_WRITE,
    CL_AMO,
    CL_DONE
  } cl_state_e;

endpackage

// File: include/hero_settings.svh
`ifndef HERO_SETTINGS_SVH
`define HERO_SETTINGS_SVH

// bus widths, address counts words
`define HERO_AW 16
`define HERO_DW 32

// subsystem size
`define HERO_N_CLUSTERS 4
`define HERO_L2_WORDS 256

// job shape, cluster i owns words i*stride onwards
`define HERO_JOB_LEN 4
`define HERO_CLUSTER_STRIDE 16

// shared completion counter, last L2 word
`define HERO_DONE_ADDR 255

`endif
